// File: logic/fpu_pkg.sv
package fpu_pkg;

    // ========================================
    // opcodes
    // ========================================

    // the encoding 7 is left out and decodes as illegal
    typedef enum logic [2:0] {
        op_fmv   = 3'd0,
        op_fneg  = 3'd1,
        op_fabs  = 3'd2,
        op_fsgnj = 3'd3,
        op_fmin  = 3'd4,
        op_fmax  = 3'd5,
        op_flt   = 3'd6
    } fpu_op_e;

    // ========================================
    // sizes and addresses
    // ========================================

    localparam int num_regs   = 32;
    localparam int reg_idx_w  = 5;
    localparam int data_w     = 16;
    localparam int num_stages = 5;

    localparam logic [11:0] addr_instr    = 12'h000;
    localparam logic [11:0] addr_status   = 12'h004;
    localparam logic [11:0] addr_stalls   = 12'h008;
    localparam logic [11:0] addr_reg_base = 12'h100;

    // quiet NaN with an empty payload
    localparam logic [data_w-1:0] canon_nan = 16'h7e00;

endpackage

// File: logic/fpu_hazard_detect.sv
`timescale 1ns/1ps

module fpu_hazard_detect import fpu_pkg::*; (
    input  logic [reg_idx_w-1:0] rs1i,
    input  logic [reg_idx_w-1:0] rs2i,
    input  logic                 use_rs1,
    input  logic                 use_rs2,
    input  logic                 is_regwrite_0,
    input  logic                 is_regwrite_1,
    input  logic                 is_regwrite_2,
    input  logic                 is_regwrite_3,
    input  logic                 is_regwrite_4,
    input  logic                 is_legal_0,
    input  logic                 is_legal_1,
    input  logic                 is_legal_2,
    input  logic                 is_legal_3,
    input  logic                 is_legal_4,
    input  logic                 is_hazard_0,
    input  logic                 is_hazard_1,
    input  logic                 is_hazard_2,
    input  logic                 is_hazard_3,
    input  logic                 is_hazard_4,
    input  logic [reg_idx_w-1:0] rdi_0,
    input  logic [reg_idx_w-1:0] rdi_1,
    input  logic [reg_idx_w-1:0] rdi_2,
    input  logic [reg_idx_w-1:0] rdi_3,
    input  logic [reg_idx_w-1:0] rdi_4,
    output logic                 hazard
);

    logic [4:0] hit;

    // a source only counts when the instruction actually reads it
    assign hit[0] = ((use_rs1 & (rs1i == rdi_0)) | (use_rs2 & (rs2i == rdi_0)))
                  & is_regwrite_0 & is_legal_0 & is_hazard_0;
    assign hit[1] = ((use_rs1 & (rs1i == rdi_1)) | (use_rs2 & (rs2i == rdi_1)))
                  & is_regwrite_1 & is_legal_1 & is_hazard_1;
    assign hit[2] = ((use_rs1 & (rs1i == rdi_2)) | (use_rs2 & (rs2i == rdi_2)))
                  & is_regwrite_2 & is_legal_2 & is_hazard_2;
    assign hit[3] = ((use_rs1 & (rs1i == rdi_3)) | (use_rs2 & (rs2i == rdi_3)))
                  & is_regwrite_3 & is_legal_3 & is_hazard_3;
    assign hit[4] = ((use_rs1 & (rs1i == rdi_4)) | (use_rs2 & (rs2i == rdi_4)))
                  & is_regwrite_4 & is_legal_4 & is_hazard_4;

    assign hazard = |hit;

endmodule

// File: logic/fpu_stage_track.sv
`timescale 1ns/1ps

module fpu_stage_track import fpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  logic                 issue_legal,
    input  logic                 issue_regwrite,
    input  logic [reg_idx_w-1:0] issue_rd,
    input  logic [data_w-1:0]    issue_result,
    input  logic                 issue_lt,
    output logic                 is_legal_0,
    output logic                 is_legal_1,
    output logic                 is_legal_2,
    output logic                 is_legal_3,
    output logic                 is_legal_4,
    output logic                 is_regwrite_0,
    output logic                 is_regwrite_1,
    output logic                 is_regwrite_2,
    output logic                 is_regwrite_3,
    output logic                 is_regwrite_4,
    output logic                 is_hazard_0,
    output logic                 is_hazard_1,
    output logic                 is_hazard_2,
    output logic                 is_hazard_3,
    output logic                 is_hazard_4,
    output logic [reg_idx_w-1:0] rdi_0,
    output logic [reg_idx_w-1:0] rdi_1,
    output logic [reg_idx_w-1:0] rdi_2,
    output logic [reg_idx_w-1:0] rdi_3,
    output logic [reg_idx_w-1:0] rdi_4,
    output logic                 wb_en,
    output logic [reg_idx_w-1:0] wb_rd,
    output logic [data_w-1:0]    wb_data,
    output logic                 flt_en,
    output logic                 flt_val,
    output logic                 busy
);

    logic [num_stages-1:0] valid_q;
    logic [num_stages-1:0] legal_q;
    logic [num_stages-1:0] regwrite_q;
    logic [num_stages-1:0] lt_q;
    logic [reg_idx_w-1:0]  rd_q [num_stages];
    logic [data_w-1:0]     result_q [num_stages];

    // an illegal instruction still occupies a slot but never writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q    <= '0;
            legal_q    <= '0;
            regwrite_q <= '0;
        end else begin
            valid_q    <= {valid_q[num_stages-2:0], issue};
            legal_q    <= {legal_q[num_stages-2:0], issue & issue_legal};
            regwrite_q <= {regwrite_q[num_stages-2:0], issue & issue_regwrite};
        end
    end

    always_ff @(posedge clk) begin
        rd_q[0]     <= issue_rd;
        result_q[0] <= issue_result;
        lt_q[0]     <= issue_lt;
        for (int k = 1; k < num_stages; k++) begin
            rd_q[k]     <= rd_q[k-1];
            result_q[k] <= result_q[k-1];
            lt_q[k]     <= lt_q[k-1];
        end
    end

    assign is_legal_0 = legal_q[0];
    assign is_legal_1 = legal_q[1];
    assign is_legal_2 = legal_q[2];
    assign is_legal_3 = legal_q[3];
    assign is_legal_4 = legal_q[4];

    assign is_regwrite_0 = regwrite_q[0];
    assign is_regwrite_1 = regwrite_q[1];
    assign is_regwrite_2 = regwrite_q[2];
    assign is_regwrite_3 = regwrite_q[3];
    assign is_regwrite_4 = regwrite_q[4];

    // the last stage is covered by the register file write-through
    assign is_hazard_0 = 1'b1;
    assign is_hazard_1 = 1'b1;
    assign is_hazard_2 = 1'b1;
    assign is_hazard_3 = 1'b1;
    assign is_hazard_4 = 1'b0;

    assign rdi_0 = rd_q[0];
    assign rdi_1 = rd_q[1];
    assign rdi_2 = rd_q[2];
    assign rdi_3 = rd_q[3];
    assign rdi_4 = rd_q[4];

    assign wb_en   = valid_q[4] & legal_q[4] & regwrite_q[4];
    assign wb_rd   = rd_q[4];
    assign wb_data = result_q[4];

    // flt is the only legal op that does not write a register
    assign flt_en  = valid_q[4] & legal_q[4] & ~regwrite_q[4];
    assign flt_val = lt_q[4];

    assign busy = |valid_q;

endmodule

// File: logic/fpu_sign_alu.sv
`timescale 1ns/1ps

module fpu_sign_alu import fpu_pkg::*; (
    input  logic [2:0]        op,
    input  logic [data_w-1:0] a,
    input  logic [data_w-1:0] b,
    output logic [data_w-1:0] result,
    output logic              lt,
    output logic              legal,
    output logic              regwrite
);

    fpu_op_e op_e;
    logic    a_nan;
    logic    b_nan;
    logic    both_zero;
    logic    ord_lt;

    assign op_e = fpu_op_e'(op);

    assign a_nan     = (a[14:10] == 5'h1f) && (a[9:0] != 10'h000);
    assign b_nan     = (b[14:10] == 5'h1f) && (b[9:0] != 10'h000);
    assign both_zero = (a[14:0] == 15'h0000) && (b[14:0] == 15'h0000);

    // total order on non-NaN values, negative zero sorts below positive zero
    always_comb begin
        if (a[15] != b[15]) begin
            ord_lt = a[15];
        end else if (a[15]) begin
            ord_lt = a[14:0] > b[14:0];
        end else begin
            ord_lt = a[14:0] < b[14:0];
        end
    end

    // flt follows IEEE, so the two zeros compare equal here
    assign lt = !a_nan && !b_nan && !both_zero && ord_lt;

    always_comb begin
        case (op_e)
            op_fmv, op_fneg, op_fabs, op_fsgnj,
            op_fmin, op_fmax, op_flt: legal = 1'b1;
            default: legal = 1'b0;
        endcase
    end

    assign regwrite = legal && (op_e != op_flt);

    always_comb begin
        case (op_e)
            op_fmv:   result = a;
            op_fneg:  result = {~a[15], a[14:0]};
            op_fabs:  result = {1'b0, a[14:0]};
            op_fsgnj: result = {b[15], a[14:0]};
            op_fmin, op_fmax: begin
                if (a_nan && b_nan) begin
                    result = canon_nan;
                end else if (a_nan) begin
                    result = b;
                end else if (b_nan) begin
                    result = a;
                end else if ((op_e == op_fmin) == ord_lt) begin
                    result = a;
                end else begin
                    result = b;
                end
            end
            default:  result = '0;
        endcase
    end

endmodule

// File: logic/fpu_regfile.sv
`timescale 1ns/1ps

module fpu_regfile import fpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [reg_idx_w-1:0] ra_idx,
    input  logic [reg_idx_w-1:0] rb_idx,
    input  logic [reg_idx_w-1:0] rh_idx,
    output logic [data_w-1:0]    ra_data,
    output logic [data_w-1:0]    rb_data,
    output logic [data_w-1:0]    rh_data,
    input  logic                 wb_en,
    input  logic [reg_idx_w-1:0] wb_rd,
    input  logic [data_w-1:0]    wb_data,
    input  logic                 hw_en,
    input  logic [reg_idx_w-1:0] hw_idx,
    input  logic [data_w-1:0]    hw_data
);

    logic [data_w-1:0] regs [num_regs];

    // same-cycle writes are visible to every read port
    function automatic logic [data_w-1:0] rd_port(input logic [reg_idx_w-1:0] idx);
        if (wb_en && (idx == wb_rd)) begin
            return wb_data;
        end else if (hw_en && (idx == hw_idx)) begin
            return hw_data;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb_en) begin
                regs[wb_rd] <= wb_data;
            end
            if (hw_en) begin
                regs[hw_idx] <= hw_data;
            end
        end
    end

    always_comb begin
        ra_data = rd_port(ra_idx);
        rb_data = rd_port(rb_idx);
        rh_data = rd_port(rh_idx);
    end

endmodule

// File: logic/fpu_apb_issue.sv
`timescale 1ns/1ps

module fpu_apb_issue import fpu_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [11:0]          paddr,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic                 hazard,
    output logic [reg_idx_w-1:0] rs1i,
    output logic [reg_idx_w-1:0] rs2i,
    output logic                 use_rs1,
    output logic                 use_rs2,
    output logic [2:0]           op,
    output logic                 issue,
    output logic                 hw_en,
    output logic [reg_idx_w-1:0] hw_idx,
    output logic [data_w-1:0]    hw_data,
    input  logic [data_w-1:0]    rh_data,
    input  logic                 flt_en,
    input  logic                 flt_val,
    input  logic                 busy
);

    fpu_op_e     op_e;
    logic        sel_instr;
    logic        sel_status;
    logic        sel_stalls;
    logic        sel_reg;
    logic        instr_wr;
    logic        op_legal;
    logic        op_two_src;
    logic        access;
    logic        done;
    logic        flt_q;
    logic [31:0] stall_cnt;

    // ========================================
    // address and instruction decode
    // ========================================

    assign sel_instr  = paddr == addr_instr;
    assign sel_status = paddr == addr_status;
    assign sel_stalls = paddr == addr_stalls;
    assign sel_reg    = (paddr[11:7] == addr_reg_base[11:7]) && (paddr[1:0] == 2'b00);

    assign op   = pwdata[2:0];
    assign op_e = fpu_op_e'(op);

    always_comb begin
        op_legal   = 1'b1;
        op_two_src = 1'b0;
        case (op_e)
            op_fmv, op_fneg, op_fabs: op_two_src = 1'b0;
            op_fsgnj, op_fmin, op_fmax, op_flt: op_two_src = 1'b1;
            default: op_legal = 1'b0;
        endcase
    end

    assign instr_wr = psel & pwrite & sel_instr;
    assign hw_idx   = paddr[2 +: reg_idx_w];
    assign hw_data  = pwdata[data_w-1:0];

    // hazard query, valid from the setup phase on
    always_comb begin
        rs1i    = pwdata[20:16];
        rs2i    = pwdata[28:24];
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        if (instr_wr) begin
            use_rs1 = op_legal;
            use_rs2 = op_legal & op_two_src;
        end else if (psel && sel_reg) begin
            rs1i    = hw_idx;
            use_rs1 = 1'b1;
        end
    end

    // ========================================
    // transfer handshake
    // ========================================

    assign access = psel & penable;
    assign done   = access & ~hazard;
    assign pready = done;

    assign issue   = done & instr_wr;
    assign hw_en   = done & pwrite & sel_reg;
    assign pslverr = done & ((instr_wr & ~op_legal)
                   | ~(sel_instr | sel_status | sel_stalls | sel_reg));

    always_comb begin
        prdata = '0;
        if (sel_status) begin
            prdata = {30'd0, busy, flt_q};
        end else if (sel_stalls) begin
            prdata = stall_cnt;
        end else if (sel_reg) begin
            prdata = {{(32 - data_w){1'b0}}, rh_data};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flt_q     <= 1'b0;
            stall_cnt <= '0;
        end else begin
            if (flt_en) begin
                flt_q <= flt_val;
            end
            if (access && hazard) begin
                stall_cnt <= stall_cnt + 32'd1;
            end
        end
    end

endmodule

// File: logic/fpu_top.sv
`timescale 1ns/1ps

module fpu_top import fpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [11:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic [reg_idx_w-1:0] rs1i;
    logic [reg_idx_w-1:0] rs2i;
    logic                 use_rs1;
    logic                 use_rs2;
    logic                 hazard;
    logic [2:0]           op;
    logic                 issue;
    logic                 hw_en;
    logic [reg_idx_w-1:0] hw_idx;
    logic [data_w-1:0]    hw_data;
    logic [data_w-1:0]    ra_data;
    logic [data_w-1:0]    rb_data;
    logic [data_w-1:0]    rh_data;
    logic [data_w-1:0]    alu_result;
    logic                 alu_lt;
    logic                 alu_legal;
    logic                 alu_regwrite;
    logic                 wb_en;
    logic [reg_idx_w-1:0] wb_rd;
    logic [data_w-1:0]    wb_data;
    logic                 flt_en;
    logic                 flt_val;
    logic                 busy;
    logic [4:0]           st_legal;
    logic [4:0]           st_regwrite;
    logic [4:0]           st_hazard;
    logic [reg_idx_w-1:0] st_rd [5];

    fpu_apb_issue u_apb (
        .clk, .rst_n, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .hazard,
        .rs1i, .rs2i, .use_rs1, .use_rs2, .op, .issue,
        .hw_en, .hw_idx, .hw_data, .rh_data, .flt_en, .flt_val, .busy
    );

    fpu_hazard_detect u_hazard (
        .rs1i, .rs2i, .use_rs1, .use_rs2,
        .is_regwrite_0(st_regwrite[0]), .is_regwrite_1(st_regwrite[1]),
        .is_regwrite_2(st_regwrite[2]), .is_regwrite_3(st_regwrite[3]),
        .is_regwrite_4(st_regwrite[4]),
        .is_legal_0(st_legal[0]), .is_legal_1(st_legal[1]), .is_legal_2(st_legal[2]),
        .is_legal_3(st_legal[3]), .is_legal_4(st_legal[4]),
        .is_hazard_0(st_hazard[0]), .is_hazard_1(st_hazard[1]),
        .is_hazard_2(st_hazard[2]), .is_hazard_3(st_hazard[3]),
        .is_hazard_4(st_hazard[4]),
        .rdi_0(st_rd[0]), .rdi_1(st_rd[1]), .rdi_2(st_rd[2]),
        .rdi_3(st_rd[3]), .rdi_4(st_rd[4]),
        .hazard
    );

    // rd rides along with the result, the sources go to the operand ports
    fpu_stage_track u_stages (
        .clk, .rst_n, .issue,
        .issue_legal(alu_legal), .issue_regwrite(alu_regwrite),
        .issue_rd(pwdata[12:8]), .issue_result(alu_result), .issue_lt(alu_lt),
        .is_legal_0(st_legal[0]), .is_legal_1(st_legal[1]), .is_legal_2(st_legal[2]),
        .is_legal_3(st_legal[3]), .is_legal_4(st_legal[4]),
        .is_regwrite_0(st_regwrite[0]), .is_regwrite_1(st_regwrite[1]),
        .is_regwrite_2(st_regwrite[2]), .is_regwrite_3(st_regwrite[3]),
        .is_regwrite_4(st_regwrite[4]),
        .is_hazard_0(st_hazard[0]), .is_hazard_1(st_hazard[1]),
        .is_hazard_2(st_hazard[2]), .is_hazard_3(st_hazard[3]),
        .is_hazard_4(st_hazard[4]),
        .rdi_0(st_rd[0]), .rdi_1(st_rd[1]), .rdi_2(st_rd[2]),
        .rdi_3(st_rd[3]), .rdi_4(st_rd[4]),
        .wb_en, .wb_rd, .wb_data, .flt_en, .flt_val, .busy
    );

    fpu_sign_alu u_alu (
        .op, .a(ra_data), .b(rb_data),
        .result(alu_result), .lt(alu_lt), .legal(alu_legal), .regwrite(alu_regwrite)
    );

    fpu_regfile u_regs (
        .clk, .rst_n,
        .ra_idx(rs1i), .rb_idx(rs2i), .rh_idx(hw_idx),
        .ra_data, .rb_data, .rh_data,
        .wb_en, .wb_rd, .wb_data, .hw_en, .hw_idx, .hw_data
    );

endmodule

// File: tests/fpu_tb.sv
`timescale 1ns/1ps

module fpu_tb import fpu_pkg::*; ();

    localparam int max_entries  = 256;
    localparam int k_write      = 0;
    localparam int k_read       = 1;
    localparam int k_instr      = 2;
    localparam int k_status     = 3;
    localparam int k_stall_up   = 4;
    localparam int k_stall_same = 5;

    logic        clk;
    logic        rst_n;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int          t_kind [max_entries];
    int          t_test [max_entries];
    logic [11:0] t_addr [max_entries];
    logic [31:0] t_data [max_entries];
    logic [31:0] t_exp  [max_entries];
    int          n_entries;
    int          watchdog_cycles = 0;
    int          test_errs [7];
    int          mismatches;
    int          num_checks;
    logic [15:0] regs_m [num_regs];
    logic        flt_m;
    logic [31:0] rng;

    fpu_top dut0 (.*);

    always #10 clk = ~clk;

    // ========================================
    // reference model
    // ========================================

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [15:0] rand_half();
        rng = xorshift(rng);
        return rng[15:0];
    endfunction

    function automatic logic is_nan(input logic [15:0] v);
        return (v[14:10] == 5'h1f) && (v[9:0] != 10'h000);
    endfunction

    // maps sign and magnitude onto an unsigned scale that grows with the value
    function automatic logic [15:0] order_key(input logic [15:0] v);
        return v[15] ? ~v : {1'b1, v[14:0]};
    endfunction

    function automatic logic model_lt(input logic [15:0] a, input logic [15:0] b);
        if (is_nan(a) || is_nan(b) || ((a[14:0] | b[14:0]) == 15'h0000)) begin
            return 1'b0;
        end
        return order_key(a) < order_key(b);
    endfunction

    function automatic logic [15:0] model_result(input logic [2:0] op,
                                                 input logic [15:0] a,
                                                 input logic [15:0] b);
        case (op)
            op_fmv:   return a;
            op_fneg:  return {~a[15], a[14:0]};
            op_fabs:  return {1'b0, a[14:0]};
            op_fsgnj: return {b[15], a[14:0]};
            op_fmin, op_fmax: begin
                if (is_nan(a) && is_nan(b)) return canon_nan;
                if (is_nan(a)) return b;
                if (is_nan(b)) return a;
                if (op == op_fmin) return (order_key(a) <= order_key(b)) ? a : b;
                return (order_key(a) >= order_key(b)) ? a : b;
            end
            default:  return a;
        endcase
    endfunction

    // ========================================
    // stimulus table
    // ========================================

    function automatic logic [11:0] reg_addr(input int n);
        return addr_reg_base + 12'(n * 4);
    endfunction

    task automatic push(input int kind, input int test, input logic [11:0] addr,
                        input logic [31:0] data, input logic [31:0] exp);
        t_kind[n_entries] = kind;
        t_test[n_entries] = test;
        t_addr[n_entries] = addr;
        t_data[n_entries] = data;
        t_exp[n_entries]  = exp;
        n_entries++;
    endtask

    task automatic add_write(input int test, input int n, input logic [15:0] v);
        regs_m[n] = v;
        push(k_write, test, reg_addr(n), {16'h0000, v}, 32'h0);
    endtask

    task automatic add_read(input int test, input int n);
        push(k_read, test, reg_addr(n), 32'h0, {16'h0000, regs_m[n]});
    endtask

    task automatic add_instr(input int test, input logic [2:0] op, input int rd,
                             input int rs1, input int rs2);
        logic [31:0] w;
        w = {3'b000, 5'(rs2), 3'b000, 5'(rs1), 3'b000, 5'(rd), 5'b00000, op};
        if (op == 3'd7) begin
            push(k_instr, test, addr_instr, w, 32'h1);
        end else begin
            if (op == op_flt) begin
                flt_m = model_lt(regs_m[rs1], regs_m[rs2]);
            end else begin
                regs_m[rd] = model_result(op, regs_m[rs1], regs_m[rs2]);
            end
            push(k_instr, test, addr_instr, w, 32'h0);
        end
    endtask

    task automatic add_op_read(input int test, input logic [2:0] op, input int rd,
                               input int rs1, input int rs2);
        add_instr(test, op, rd, rs1, rs2);
        add_read(test, rd);
    endtask

    // flt, then a read of its rd, then the status word
    task automatic add_flt(input int rs1, input int rs2);
        add_op_read(4, op_flt, 9, rs1, rs2);
        push(k_status, 4, addr_status, 32'h0, {31'h0, flt_m});
    endtask

    task automatic build_table();
        for (int n = 0; n < num_regs; n++) add_write(1, n, rand_half());
        for (int n = 0; n < num_regs; n++) add_read(1, n);

        add_op_read(2, op_fmv, 10, 1, 0);
        add_op_read(2, op_fneg, 11, 2, 0);
        add_op_read(2, op_fabs, 12, 3, 0);
        add_op_read(2, op_fsgnj, 13, 4, 5);
        add_op_read(2, op_fneg, 14, 14, 0);

        add_write(3, 20, 16'h8000);
        add_write(3, 21, 16'h0000);
        add_write(3, 22, 16'h7e01);
        add_write(3, 23, 16'hfd00);
        add_write(3, 24, 16'h3c00);
        add_op_read(3, op_fmin, 25, 20, 21);
        add_op_read(3, op_fmin, 25, 21, 20);
        add_op_read(3, op_fmax, 26, 20, 21);
        add_op_read(3, op_fmax, 26, 21, 20);
        add_op_read(3, op_fmin, 27, 22, 24);
        add_op_read(3, op_fmax, 27, 24, 22);
        add_op_read(3, op_fmin, 28, 22, 23);
        add_op_read(3, op_fmax, 28, 23, 22);
        for (int j = 0; j < 6; j++) begin
            add_write(3, 29, rand_half());
            add_write(3, 30, rand_half());
            add_op_read(3, op_fmin, 31, 29, 30);
            add_op_read(3, op_fmax, 31, 29, 30);
        end

        add_write(4, 7, 16'h3c00);
        add_write(4, 8, 16'h4000);
        add_flt(7, 8);
        add_flt(20, 21);
        add_flt(7, 8);
        add_flt(7, 22);
        add_flt(29, 30);

        // each instruction reads the rd of the one before it
        add_instr(5, op_fneg, 15, 1, 0);
        add_instr(5, op_fsgnj, 16, 15, 15);
        add_instr(5, op_fmax, 17, 16, 15);
        add_instr(5, op_fmin, 18, 2, 17);
        add_read(5, 18);
        add_read(5, 16);
        add_read(5, 17);
        push(k_stall_up, 5, addr_stalls, 32'h0, 32'h0);
        add_instr(5, op_fabs, 15, 18, 0);
        add_instr(5, op_fneg, 15, 15, 0);
        add_read(5, 15);
        push(k_stall_up, 5, addr_stalls, 32'h0, 32'h0);
        add_instr(5, op_fmin, 19, 1, 2);
        add_instr(5, op_fmax, 20, 3, 4);
        add_instr(5, op_fsgnj, 21, 5, 6);
        // the last instruction is still in flight, so the busy bit is up
        push(k_status, 5, addr_status, 32'h0, {30'h0, 1'b1, flt_m});
        push(k_stall_same, 5, addr_stalls, 32'h0, 32'h0);
        add_read(5, 19);
        add_read(5, 20);
        add_read(5, 21);

        add_instr(6, 3'd7, 3, 1, 2);
        for (int n = 0; n < num_regs; n++) add_read(6, n);
    endtask

    // ========================================
    // bus driver, checks and reporting
    // ========================================

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready) begin
            @(negedge clk);
            #1;
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check(input int test, input string name, input logic [31:0] exp,
                         input logic [31:0] act);
        num_checks++;
        if (exp !== act) begin
            mismatches++;
            test_errs[test]++;
            $display("mismatch %s: expected 0x%08h, got 0x%08h", name, exp, act);
        end
    endtask

    function automatic string test_name(input int id);
        case (id)
            1:       return "register window";
            2:       return "sign operations";
            3:       return "fmin and fmax";
            4:       return "flt status";
            5:       return "dependent chains";
            default: return "illegal opcode";
        endcase
    endfunction

    task automatic report_test(input int id);
        if (test_errs[id] == 0) begin
            $display("test %0d %s: ok", id, test_name(id));
        end else begin
            $display("test %0d %s: failed with %0d mismatches", id, test_name(id),
                     test_errs[id]);
        end
    endtask

    initial begin
        int          cur;
        int          passed;
        logic [31:0] rdata;
        logic        err;
        logic [31:0] last_stalls;
        clk     = 1'b0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        rng        = 32'd41194;
        n_entries  = 0;
        mismatches = 0;
        num_checks = 0;
        flt_m      = 1'b0;
        last_stalls = 32'h0;
        for (int n = 0; n < num_regs; n++) regs_m[n] = 16'h0000;
        for (int t = 0; t < 7; t++) test_errs[t] = 0;
        build_table();
        watchdog_cycles = n_entries * 40 + 200;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < n_entries; i++) begin
            apb_xfer(t_kind[i] == k_write || t_kind[i] == k_instr, t_addr[i], t_data[i],
                     rdata, err);
            cur = t_test[i];
            case (t_kind[i])
                k_write, k_instr: check(cur, "pslverr", t_exp[i], {31'h0, err});
                k_read:           check(cur, "prdata", t_exp[i], rdata);
                k_status:         check(cur, "status", t_exp[i], rdata);
                k_stall_up: begin
                    check(cur, "stall_cnt rising", 32'h1,
                          {31'h0, (rdata != 32'h0) && (rdata >= last_stalls)});
                    last_stalls = rdata;
                end
                default: begin
                    check(cur, "stall_cnt", last_stalls, rdata);
                    last_stalls = rdata;
                end
            endcase
            // every read targets a mapped address
            if (t_kind[i] != k_write && t_kind[i] != k_instr) begin
                check(cur, "pslverr", 32'h0, {31'h0, err});
            end
            if (i == n_entries - 1 || t_test[i + 1] != cur) report_test(cur);
        end

        passed = 0;
        for (int t = 1; t < 7; t++) begin
            if (test_errs[t] == 0) passed++;
        end
        $display("summary: %0d of 6 tests passed, %0d checks, %0d mismatches",
                 passed, num_checks, mismatches);
        if (mismatches == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the stimulus table did not finish within %0d cycles",
                 watchdog_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: all.f
logic/fpu_pkg.sv
logic/fpu_hazard_detect.sv
logic/fpu_stage_track.sv
logic/fpu_sign_alu.sv
logic/fpu_regfile.sv
logic/fpu_apb_issue.sv
logic/fpu_top.sv
tests/fpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module fpu_tb -f all.f -o fpu_sim

./obj_dir/fpu_sim | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
